//--- src/io_regs_pkg.sv
// Register map, port pin constants and host bus / port access structs
`default_nettype none

package io_regs_pkg;

	localparam int NUM_PORTS = 3;
	localparam int PIN_W = 7;
	localparam int ADDR_W = 4;
	localparam int SER_REGS = 3;	// txd, rxd, serial control per port

	// Pins with a fixed role
	localparam int PIN_TX = 4;
	localparam int PIN_RX = 5;
	localparam int PIN_INT = 6;

	//////////////////////////////////////////////////
	// Register map
	localparam logic [ADDR_W-1:0] ADDR_VERSION = 4'd0;
	localparam logic [ADDR_W-1:0] ADDR_DATA_BASE = 4'd1;
	localparam logic [ADDR_W-1:0] ADDR_CTRL_BASE = 4'd4;
	localparam logic [ADDR_W-1:0] ADDR_SER_BASE = 4'd7;

	localparam logic [7:0] VERSION_ID = 8'ha1;

	typedef struct packed {
		logic we;
		logic rd;
		logic [ADDR_W-1:0] addr;
		logic [7:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic data_we;
		logic ctrl_we;
		logic txd_we;
		logic sctrl_we;
		logic rxd_rd;
		logic [7:0] wdata;
	} port_wr_t;

	typedef struct packed {
		logic [7:0] data;
		logic [7:0] ctrl;
		logic [7:0] txd;
		logic [7:0] rxd;
		logic [7:0] status;
	} port_rd_t;

	typedef struct packed {
		logic [1:0] rate;
		logic rx_en;
		logic tx_en;
		logic rx_irq_en;
	} ser_ctrl_t;

endpackage

`default_nettype wire

//--- src/io_serial_pkg.sv
// Serial frame constants, baud rate taps and tick strobe struct
`default_nettype none

package io_serial_pkg;

	localparam int FRAME_BITS = 8;
	localparam int FRAME_LEN = FRAME_BITS + 2;	// Start and stop bits added
	localparam int OVERSAMPLE = 16;
	localparam int PRESCALE = 2;
	localparam int NUM_RATES = 4;

	// Base ticks per receive tick, by rate
	localparam logic [NUM_RATES-1:0][15:0] RX_TAPS = {16'd16, 16'd4, 16'd2, 16'd1};

	typedef struct packed {
		logic [NUM_RATES-1:0] rx_tick;
		logic [NUM_RATES-1:0] tx_tick;
	} baud_ticks_t;

endpackage

`default_nettype wire

//--- src/io_baud_gen.sv
// Baud generator: prescaler and divider chain giving rx and tx tick strobes
`timescale 1ns/100ps
`default_nettype none

module io_baud_gen
	import io_serial_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	output baud_ticks_t ticks_o
);

	localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
	localparam int DIV_W = $clog2(RX_TAPS[NUM_RATES-1] * OVERSAMPLE);

	logic [PRE_W-1:0] pre_cnt;
	logic [DIV_W-1:0] div_cnt;
	logic base_tick;

	assign base_tick = (pre_cnt == PRE_W'(PRESCALE - 1));

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pre_cnt <= '0;
			div_cnt <= '0;
		end
		else
		begin
			pre_cnt <= base_tick ? '0 : pre_cnt + 1'b1;
			if (base_tick)
				div_cnt <= div_cnt + 1'b1;	// Free running
		end
	end

	// Each tap fires when the low bits of the divider are zero
	always_comb
	begin
		for (int r = 0; r < NUM_RATES; r++)
		begin
			ticks_o.rx_tick[r] = base_tick &&
				((div_cnt & DIV_W'(RX_TAPS[r] - 1)) == '0);
			ticks_o.tx_tick[r] = base_tick &&
				((div_cnt & DIV_W'(RX_TAPS[r] * OVERSAMPLE - 1)) == '0);
		end
	end

endmodule

`default_nettype wire

//--- src/io_uart_tx.sv
// Serial transmitter: frame shifter, bit counter and busy flag
`timescale 1ns/100ps
`default_nettype none

module io_uart_tx
	import io_regs_pkg::*, io_serial_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire logic tx_tick_i,
	input wire logic txd_we_i,
	input wire logic [7:0] txd_i,
	input wire logic tx_en_i,
	output logic tx_line_o,
	output logic tx_busy_o
);

	localparam int BC_W = $clog2(FRAME_LEN);

	logic pend;	// Byte waiting for a frame slot
	logic sending;
	logic [BC_W-1:0] bit_cnt;
	logic [FRAME_LEN-1:0] shifter;
	logic frame_slot;

	// Idle tick or end of stop bit
	assign frame_slot = tx_tick_i && (!sending || bit_cnt == BC_W'(FRAME_LEN - 1));

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pend <= 1'b0;
			sending <= 1'b0;
			bit_cnt <= '0;
			shifter <= '1;
		end
		else
		begin
			if (tx_en_i && frame_slot)
				pend <= 1'b0;
			if (txd_we_i)
				pend <= 1'b1;	// Later write replaces the waiting byte

			if (!tx_en_i)
			begin
				sending <= 1'b0;
				bit_cnt <= '0;
				shifter <= '1;
			end
			else if (frame_slot)
			begin
				sending <= pend;
				bit_cnt <= '0;
				shifter <= pend ? {1'b1, txd_i, 1'b0} : '1;	// Stop, data, start
			end
			else if (tx_tick_i)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				shifter <= {1'b1, shifter[FRAME_LEN-1:1]};	// LSB first
			end
		end
	end

	assign tx_line_o = shifter[0];
	assign tx_busy_o = pend || sending;

endmodule

`default_nettype wire

//--- src/io_uart_rx.sv
// Serial receiver: oversampled start detect, data shifter, ready and error flags
`timescale 1ns/100ps
`default_nettype none

module io_uart_rx
	import io_regs_pkg::*, io_serial_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire logic rx_tick_i,
	input wire logic rx_line_i,
	input wire logic rx_en_i,
	input wire logic rxd_rd_i,
	output logic [7:0] rxd_o,
	output logic rx_ready_o,
	output logic rx_error_o
);

	localparam int TC_W = $clog2(OVERSAMPLE);
	localparam int BC_W = $clog2(FRAME_BITS);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_phase_t;

	rx_phase_t phase;
	logic [TC_W-1:0] tick_cnt;
	logic [BC_W-1:0] bit_cnt;
	logic [1:0] line_sync;
	logic line_s;
	logic sample_pt;
	logic [FRAME_BITS-1:0] shifter;
	logic [FRAME_BITS-1:0] rxd_q;

	assign line_s = line_sync[1];

	// Half a bit for the start bit, full bits after it
	assign sample_pt = rx_tick_i && ((phase == RX_START) ?
		(tick_cnt == TC_W'(OVERSAMPLE / 2 - 1)) :
		(tick_cnt == TC_W'(OVERSAMPLE - 1)));

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			line_sync <= '1;
			phase <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			rx_ready_o <= 1'b0;
			rx_error_o <= 1'b0;
		end
		else
		begin
			line_sync <= {line_sync[0], rx_line_i};
			if (rxd_rd_i)
			begin
				rx_ready_o <= 1'b0;
				rx_error_o <= 1'b0;
			end

			if (!rx_en_i)
				phase <= RX_IDLE;
			else if (rx_tick_i)
			begin
				tick_cnt <= sample_pt ? '0 : tick_cnt + 1'b1;
				case (phase)
					RX_IDLE:
					begin
						tick_cnt <= '0;
						if (!line_s)
							phase <= RX_START;
					end
					RX_START:
						if (sample_pt)
						begin
							bit_cnt <= '0;
							phase <= line_s ? RX_IDLE : RX_DATA;	// Glitch rejected
						end
					RX_DATA:
						if (sample_pt)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BC_W'(FRAME_BITS - 1))
								phase <= RX_STOP;
						end
					default:
						if (sample_pt)
						begin
							rx_ready_o <= 1'b1;
							rx_error_o <= !line_s;	// Low stop bit
							phase <= RX_IDLE;
						end
				endcase
			end
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (phase == RX_DATA && sample_pt)
			shifter <= {line_s, shifter[FRAME_BITS-1:1]};
		if (phase == RX_STOP && sample_pt)
			rxd_q <= shifter;
	end

	assign rxd_o = rxd_q;

endmodule

`default_nettype wire

//--- src/io_port.sv
// Controller port: data, control and serial registers, pin drive and interrupt
`timescale 1ns/100ps
`default_nettype none

module io_port
	import io_regs_pkg::*, io_serial_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire port_wr_t wr_i,
	input wire baud_ticks_t ticks_i,
	input wire logic [PIN_W-1:0] pin_i,
	output logic [PIN_W-1:0] pin_o,
	output logic [PIN_W-1:0] pin_oe_o,
	output port_rd_t rd_o,
	output logic irq_o
);

	logic [7:0] data_q;
	logic [7:0] ctrl_q;
	logic [7:0] txd_q;
	ser_ctrl_t sctrl_q;
	logic rx_tick;
	logic tx_tick;
	logic tx_line;
	logic tx_busy;
	logic [7:0] rxd;
	logic rx_ready;
	logic rx_error;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			ctrl_q <= '0;
			sctrl_q <= '0;
		end
		else
		begin
			if (wr_i.ctrl_we)
				ctrl_q <= wr_i.wdata;
			if (wr_i.sctrl_we)
				sctrl_q <= ser_ctrl_t'(wr_i.wdata[7:3]);
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (wr_i.data_we)
			data_q <= wr_i.wdata;
		if (wr_i.txd_we)
			txd_q <= wr_i.wdata;
	end

	assign rx_tick = ticks_i.rx_tick[sctrl_q.rate];
	assign tx_tick = ticks_i.tx_tick[sctrl_q.rate];

	io_uart_tx u_tx (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.tx_tick_i(tx_tick),
		.txd_we_i(wr_i.txd_we),
		.txd_i(txd_q),
		.tx_en_i(sctrl_q.tx_en),
		.tx_line_o(tx_line),
		.tx_busy_o(tx_busy)
	);

	io_uart_rx u_rx (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.rx_tick_i(rx_tick),
		.rx_line_i(pin_i[PIN_RX]),
		.rx_en_i(sctrl_q.rx_en),
		.rxd_rd_i(wr_i.rxd_rd),
		.rxd_o(rxd),
		.rx_ready_o(rx_ready),
		.rx_error_o(rx_error)
	);

	//////////////////////////////////////////////////
	// Pin drive, serial enables override direction
	always_comb
	begin
		pin_o = data_q[PIN_W-1:0];
		pin_oe_o = ctrl_q[PIN_W-1:0];
		if (sctrl_q.tx_en)
		begin
			pin_o[PIN_TX] = tx_line;
			pin_oe_o[PIN_TX] = 1'b1;
		end
		if (sctrl_q.rx_en)
			pin_oe_o[PIN_RX] = 1'b0;
	end

	assign rd_o.data = {data_q[7], pin_i};
	assign rd_o.ctrl = ctrl_q;
	assign rd_o.txd = txd_q;
	assign rd_o.rxd = rxd;
	assign rd_o.status = {sctrl_q, rx_error, rx_ready, tx_busy};

	// Control bit 7 enables the pin 6 interrupt
	assign irq_o = (ctrl_q[7] && !pin_i[PIN_INT]) || (rx_ready && sctrl_q.rx_irq_en);

endmodule

`default_nettype wire

//--- src/io_reg_access.sv
// Register access: address decode, port strobes, read mux and read data register
`timescale 1ns/100ps
`default_nettype none

module io_reg_access
	import io_regs_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire bus_req_t bus_req_i,
	input wire port_rd_t [NUM_PORTS-1:0] port_rd_i,
	output port_wr_t [NUM_PORTS-1:0] port_wr_o,
	output logic [7:0] rdata_o,
	output logic rd_valid_o
);

	logic [7:0] rd_mux;

	//////////////////////////////////////////////////
	// Decode
	always_comb
	begin
		rd_mux = 8'h00;
		if (bus_req_i.addr == ADDR_VERSION)
			rd_mux = VERSION_ID;

		for (int p = 0; p < NUM_PORTS; p++)
		begin
			logic [ADDR_W-1:0] data_addr;
			logic [ADDR_W-1:0] ctrl_addr;
			logic [ADDR_W-1:0] ser_addr;

			data_addr = ADDR_DATA_BASE + ADDR_W'(p);
			ctrl_addr = ADDR_CTRL_BASE + ADDR_W'(p);
			ser_addr = ADDR_SER_BASE + ADDR_W'(SER_REGS * p);	// Start of serial group

			port_wr_o[p].wdata = bus_req_i.wdata;
			port_wr_o[p].data_we = bus_req_i.we && (bus_req_i.addr == data_addr);
			port_wr_o[p].ctrl_we = bus_req_i.we && (bus_req_i.addr == ctrl_addr);
			port_wr_o[p].txd_we = bus_req_i.we && (bus_req_i.addr == ser_addr);
			port_wr_o[p].sctrl_we = bus_req_i.we && (bus_req_i.addr == ser_addr + 2'd2);
			port_wr_o[p].rxd_rd = bus_req_i.rd && (bus_req_i.addr == ser_addr + 2'd1);

			if (bus_req_i.addr == data_addr)
				rd_mux = port_rd_i[p].data;
			if (bus_req_i.addr == ctrl_addr)
				rd_mux = port_rd_i[p].ctrl;
			if (bus_req_i.addr == ser_addr)
				rd_mux = port_rd_i[p].txd;
			if (bus_req_i.addr == ser_addr + 2'd1)
				rd_mux = port_rd_i[p].rxd;
			if (bus_req_i.addr == ser_addr + 2'd2)
				rd_mux = port_rd_i[p].status;
		end
	end

	//////////////////////////////////////////////////
	// Read data, one cycle after the strobe
	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			rd_valid_o <= 1'b0;
		else
			rd_valid_o <= bus_req_i.rd;
	end

	always_ff @(posedge MCLK)
	begin
		if (bus_req_i.rd)
			rdata_o <= rd_mux;	// Held until next read
	end

endmodule

`default_nettype wire

//--- src/io_ctrl.sv
// I/O controller top: baud generator, register access and three controller ports
`timescale 1ns/100ps
`default_nettype none

module io_ctrl
	import io_regs_pkg::*, io_serial_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire bus_req_t bus_req_i,
	input wire logic [PIN_W-1:0] pin_a_i,
	input wire logic [PIN_W-1:0] pin_b_i,
	input wire logic [PIN_W-1:0] pin_c_i,
	output logic [PIN_W-1:0] pin_a_o,
	output logic [PIN_W-1:0] pin_b_o,
	output logic [PIN_W-1:0] pin_c_o,
	output logic [PIN_W-1:0] pin_a_oe_o,
	output logic [PIN_W-1:0] pin_b_oe_o,
	output logic [PIN_W-1:0] pin_c_oe_o,
	output logic [7:0] rdata_o,
	output logic rd_valid_o,
	output logic irq_o
);

	baud_ticks_t ticks;
	port_wr_t [NUM_PORTS-1:0] port_wr;
	port_rd_t [NUM_PORTS-1:0] port_rd;
	logic [NUM_PORTS-1:0] port_irq;

	io_baud_gen u_baud_gen (.MCLK(MCLK), .reset_i(reset_i), .ticks_o(ticks));

	io_reg_access u_reg_access (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.bus_req_i(bus_req_i),
		.port_rd_i(port_rd),
		.port_wr_o(port_wr),
		.rdata_o(rdata_o),
		.rd_valid_o(rd_valid_o)
	);

	io_port u_port_a (.MCLK(MCLK), .reset_i(reset_i), .wr_i(port_wr[0]), .ticks_i(ticks),
		.pin_i(pin_a_i), .pin_o(pin_a_o), .pin_oe_o(pin_a_oe_o),
		.rd_o(port_rd[0]), .irq_o(port_irq[0]));

	io_port u_port_b (.MCLK(MCLK), .reset_i(reset_i), .wr_i(port_wr[1]), .ticks_i(ticks),
		.pin_i(pin_b_i), .pin_o(pin_b_o), .pin_oe_o(pin_b_oe_o),
		.rd_o(port_rd[1]), .irq_o(port_irq[1]));

	io_port u_port_c (.MCLK(MCLK), .reset_i(reset_i), .wr_i(port_wr[2]), .ticks_i(ticks),
		.pin_i(pin_c_i), .pin_o(pin_c_o), .pin_oe_o(pin_c_oe_o),
		.rd_o(port_rd[2]), .irq_o(port_irq[2]));

	assign irq_o = |port_irq;	// Merged host interrupt

endmodule

`default_nettype wire

//--- bench/io_ctrl_chk.sv
// Bound assertions: read valid timing, receive pin direction, interrupt after reset
`timescale 1ns/100ps
`default_nettype none

module io_ctrl_chk
	import io_regs_pkg::*;
(
	input wire logic MCLK,
	input wire logic reset_i,
	input wire bus_req_t bus_req_i,
	input wire logic [PIN_W-1:0] pin_a_oe_i,
	input wire logic [PIN_W-1:0] pin_b_oe_i,
	input wire logic [PIN_W-1:0] pin_c_oe_i,
	input wire logic rd_valid_i,
	input wire logic irq_i
);

	localparam int SCTRL_RX_EN = 5;	// rx_en position in the written byte

	int unsigned rd_valid_fails = 0;
	int unsigned oe_fails = 0;
	int unsigned irq_fails = 0;
	logic [NUM_PORTS-1:0] rx_en_last;
	logic [NUM_PORTS-1:0] rx_pin_oe;

	assign rx_pin_oe = {pin_c_oe_i[PIN_RX], pin_b_oe_i[PIN_RX], pin_a_oe_i[PIN_RX]};

	// Receive enable of the last serial control write, per port
	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			rx_en_last <= '0;
		else if (bus_req_i.we)
			for (int p = 0; p < NUM_PORTS; p++)
				if (bus_req_i.addr == ADDR_SER_BASE + ADDR_W'(3 * p + 2))
					rx_en_last[p] <= bus_req_i.wdata[SCTRL_RX_EN];
	end

	//////////////////////////////////////////////////
	// Read valid exactly one cycle after each strobe
	rd_valid_after_rd: assert property (@(posedge MCLK) disable iff (reset_i)
		bus_req_i.rd |=> rd_valid_i)
	else
	begin
		$error("rd_valid_o missing one cycle after a read strobe");
		rd_valid_fails++;
	end

	rd_valid_only_after_rd: assert property (@(posedge MCLK) disable iff (reset_i)
		!bus_req_i.rd |=> !rd_valid_i)
	else
	begin
		$error("rd_valid_o high without a read strobe");
		rd_valid_fails++;
	end

	rx_pin_input: assert property (@(posedge MCLK) disable iff (reset_i)
		(rx_en_last & rx_pin_oe) == '0)
	else
	begin
		$error("pin 5 output enable set while receiver enabled");
		oe_fails++;
	end

	irq_low_after_reset: assert property (@(posedge MCLK) $fell(reset_i) |-> !irq_i)
	else
	begin
		$error("irq_o high in the first cycle after reset");
		irq_fails++;
	end

endmodule

`default_nettype wire

//--- bench/io_ctrl_tb.sv
// Testbench for the I/O controller with clock, reset, stimulus, checks and closing report
`timescale 1ns/100ps
`default_nettype none

module io_ctrl_tb
	import io_regs_pkg::*, io_serial_pkg::*;
();

	localparam int BIT_CYC = PRESCALE * RX_TAPS[0] * OVERSAMPLE;	// MCLK cycles per bit at rate 0
	localparam int POLL_LIMIT = 2000;

	logic MCLK;
	logic reset_i;
	bus_req_t bus_req;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_drv;
	wire logic [PIN_W-1:0] pin_a_i;
	wire logic [PIN_W-1:0] pin_b_i;
	wire logic [PIN_W-1:0] pin_c_i;
	logic [PIN_W-1:0] pin_a_o;
	logic [PIN_W-1:0] pin_b_o;
	logic [PIN_W-1:0] pin_c_o;
	logic [PIN_W-1:0] pin_a_oe_o;
	logic [PIN_W-1:0] pin_b_oe_o;
	logic [PIN_W-1:0] pin_c_oe_o;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_in;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_out;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_oe;
	logic [7:0] rdata;
	logic rd_valid;
	logic irq;
	int checks;
	int mismatches;
	int timeouts;

	// Port A transmit line loops into port B receive pin
	assign pin_a_i = pin_drv[0];
	assign pin_b_i = {pin_drv[1][6], pin_a_o[PIN_TX], pin_drv[1][4:0]};
	assign pin_c_i = pin_drv[2];
	assign pin_in = {pin_c_i, pin_b_i, pin_a_i};
	assign pin_out = {pin_c_o, pin_b_o, pin_a_o};
	assign pin_oe = {pin_c_oe_o, pin_b_oe_o, pin_a_oe_o};

	always #4 MCLK = ~MCLK;

	io_ctrl u_io_ctrl (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.bus_req_i(bus_req),
		.pin_a_i(pin_a_i),
		.pin_b_i(pin_b_i),
		.pin_c_i(pin_c_i),
		.pin_a_o(pin_a_o),
		.pin_b_o(pin_b_o),
		.pin_c_o(pin_c_o),
		.pin_a_oe_o(pin_a_oe_o),
		.pin_b_oe_o(pin_b_oe_o),
		.pin_c_oe_o(pin_c_oe_o),
		.rdata_o(rdata),
		.rd_valid_o(rd_valid),
		.irq_o(irq)
	);

	bind io_ctrl io_ctrl_chk u_chk (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.bus_req_i(bus_req_i),
		.pin_a_oe_i(pin_a_oe_o),
		.pin_b_oe_i(pin_b_oe_o),
		.pin_c_oe_i(pin_c_oe_o),
		.rd_valid_i(rd_valid_o),
		.irq_i(irq_o)
	);

	//////////////////////////////////////////////////
	// Bus access and checking helpers
	function automatic logic [3:0] ser_reg_addr(input int p, input int offset);
		return ADDR_SER_BASE + 4'(3 * p + offset);	// txd, rxd, status
	endfunction

	task automatic finish_run();
		int asrt_fails;
		asrt_fails = u_io_ctrl.u_chk.rd_valid_fails + u_io_ctrl.u_chk.oe_fails
			+ u_io_ctrl.u_chk.irq_fails;
		$display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, mismatches, timeouts, asrt_fails);
		if (mismatches == 0 && timeouts == 0 && asrt_fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		timeouts++;
		finish_run();
	endtask

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
		@(negedge MCLK);
		bus_req = '{we: 1'b1, rd: 1'b0, addr: addr, wdata: data};
		@(negedge MCLK);
		bus_req = '0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [7:0] data);
		int waited;
		@(negedge MCLK);
		bus_req = '{we: 1'b0, rd: 1'b1, addr: addr, wdata: 8'h00};
		@(negedge MCLK);
		bus_req = '0;
		waited = 0;
		while (!rd_valid && waited < 4)
		begin
			@(negedge MCLK);
			waited++;
		end
		if (!rd_valid)
			fail_timeout("read data valid");
		data = rdata;
	endtask

	task automatic verify_reg(input string name, input logic [3:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		read_reg(addr, got);
		compare($sformatf("rdata_o[%h] %s", addr, name), got, exp);
	endtask

	// Reads a register until the masked bits match
	task automatic poll_status(input string name, input logic [3:0] addr,
		input logic [7:0] mask, input logic [7:0] exp);
		int polls;
		logic [7:0] val;
		polls = 0;
		read_reg(addr, val);
		while ((val & mask) != exp && polls < POLL_LIMIT)
		begin
			read_reg(addr, val);
			polls++;
		end
		if ((val & mask) != exp)
			fail_timeout(name);
	endtask

	task automatic await_irq(input logic level);
		int waited;
		waited = 0;
		do
		begin
			@(negedge MCLK);
			waited++;
		end
		while (irq !== level && waited < POLL_LIMIT);
		if (irq !== level)
			fail_timeout($sformatf("irq_o to become %0d", level));
	endtask

	// Serial frame into port C with the stop bit held low
	task automatic drive_bad_frame(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b0, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(negedge MCLK);
			pin_drv[2][PIN_RX] = frame[i];
			repeat ((i == 9) ? BIT_CYC * 3 / 4 : BIT_CYC - 1) @(negedge MCLK);
		end
		pin_drv[2][PIN_RX] = 1'b1;	// Short stop so no new frame starts
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	initial
	begin
		logic [7:0] d;
		logic [7:0] c;
		logic [7:0] tx_byte;
		logic [7:0] bad_byte;
		logic [PIN_W-1:0] oe_exp;
		logic [PIN_W-1:0] out_exp;
		MCLK = 1'b0;
		reset_i = 1'b1;
		bus_req = '0;
		pin_drv = {NUM_PORTS{7'h7f}};
		checks = 0;
		mismatches = 0;
		timeouts = 0;
		void'($urandom(48));
		repeat (2) @(negedge MCLK);
		reset_i = 1'b0;

		// Reset state
		@(negedge MCLK);
		compare("irq_o", irq, 8'h00);
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			compare($sformatf("pin_oe_o port %0d", p), pin_oe[p], 8'h00);
			verify_reg("control", ADDR_CTRL_BASE + 4'(p), 8'h00);
			verify_reg("serial status", ser_reg_addr(p, 2), 8'h00);
		end

		// Parallel data and direction
		for (int n = 0; n < 6; n++)
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				d = 8'($urandom);
				c = 8'($urandom);
				pin_drv[p] = 7'($urandom);
				write_reg(ADDR_DATA_BASE + 4'(p), d);
				write_reg(ADDR_CTRL_BASE + 4'(p), c);
				compare($sformatf("pin_o port %0d", p), pin_out[p], d[6:0]);
				compare($sformatf("pin_oe_o port %0d", p), pin_oe[p], c[6:0]);
				verify_reg("data", ADDR_DATA_BASE + 4'(p), {d[7], pin_in[p]});
			end
		pin_drv = {NUM_PORTS{7'h7f}};
		for (int p = 0; p < NUM_PORTS; p++)
			write_reg(ADDR_CTRL_BASE + 4'(p), 8'h00);

		// Loopback A to B at rate 0
		write_reg(ser_reg_addr(0, 2), 8'h10);	// tx_en
		write_reg(ser_reg_addr(1, 2), 8'h20);	// rx_en
		tx_byte = 8'($urandom);
		write_reg(ser_reg_addr(0, 0), tx_byte);
		verify_reg("port A status", ser_reg_addr(0, 2), 8'h11);	// tx_busy while sending
		poll_status("port B rx_ready", ser_reg_addr(1, 2), 8'h02, 8'h02);
		compare("irq_o", irq, 8'h00);	// rx_irq_en clear
		verify_reg("port B status", ser_reg_addr(1, 2), 8'h22);
		verify_reg("port B rxd", ser_reg_addr(1, 1), tx_byte);
		verify_reg("port B status after read", ser_reg_addr(1, 2), 8'h20);
		poll_status("port A tx_busy to clear", ser_reg_addr(0, 2), 8'h01, 8'h00);

		// Framing error on C
		write_reg(ser_reg_addr(2, 2), 8'h20);
		bad_byte = 8'($urandom);
		drive_bad_frame(bad_byte);
		poll_status("port C rx_ready", ser_reg_addr(2, 2), 8'h02, 8'h02);
		verify_reg("port C status", ser_reg_addr(2, 2), 8'h26);
		verify_reg("port C rxd", ser_reg_addr(2, 1), bad_byte);

		// Pin 6 interrupt
		pin_drv[2][PIN_INT] = 1'b0;
		@(negedge MCLK);
		compare("irq_o", irq, 8'h00);	// Pin 6 low while control bit 7 clear
		write_reg(ADDR_CTRL_BASE + 4'd2, 8'h80);
		await_irq(1'b1);
		pin_drv[2][PIN_INT] = 1'b1;
		await_irq(1'b0);
		write_reg(ADDR_CTRL_BASE + 4'd2, 8'h00);

		// Receive interrupt on B
		write_reg(ser_reg_addr(1, 2), 8'h28);
		tx_byte = 8'($urandom);
		write_reg(ser_reg_addr(0, 0), tx_byte);
		await_irq(1'b1);
		verify_reg("port B rxd", ser_reg_addr(1, 1), tx_byte);
		await_irq(1'b0);
		poll_status("port A tx_busy to clear", ser_reg_addr(0, 2), 8'h01, 8'h00);

		// Register map
		verify_reg("version", ADDR_VERSION, VERSION_ID);
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			d = 8'($urandom);
			c = (8'($urandom) & 8'h4f) | 8'h20;	// Pin 5 out, pin 4 in, no pin 6 interrupt
			write_reg(ADDR_DATA_BASE + 4'(p), d);
			write_reg(ADDR_CTRL_BASE + 4'(p), c);
			oe_exp = c[6:0];
			out_exp = d[6:0];
			if (p == 0)
			begin
				oe_exp[PIN_TX] = 1'b1;	// Transmitter drives pin 4
				out_exp[PIN_TX] = 1'b1;	// Idle line
			end
			else
				oe_exp[PIN_RX] = 1'b0;	// Receiver on pin 5
			compare($sformatf("pin_oe_o port %0d", p), pin_oe[p], oe_exp);
			compare($sformatf("pin_o port %0d", p), pin_out[p], out_exp);
			verify_reg("data", ADDR_DATA_BASE + 4'(p), {d[7], pin_in[p]});
			verify_reg("control", ADDR_CTRL_BASE + 4'(p), c);
		end
		verify_reg("port A status", ser_reg_addr(0, 2), 8'h10);
		verify_reg("port B status", ser_reg_addr(1, 2), 8'h28);
		verify_reg("port C status", ser_reg_addr(2, 2), 8'h20);
		verify_reg("port B rxd", ser_reg_addr(1, 1), tx_byte);
		verify_reg("port C rxd", ser_reg_addr(2, 1), bad_byte);
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			d = 8'($urandom);
			write_reg(ser_reg_addr(p, 0), d);
			verify_reg("txd", ser_reg_addr(p, 0), d);
		end

		finish_run();
	end

endmodule

`default_nettype wire

//--- io_ctrl.f
src/io_regs_pkg.sv
src/io_serial_pkg.sv
src/io_baud_gen.sv
src/io_uart_tx.sv
src/io_uart_rx.sv
src/io_port.sv
src/io_reg_access.sv
src/io_ctrl.sv
bench/io_ctrl_chk.sv
bench/io_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the I/O controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module io_ctrl_tb -Mdir obj_dir -f io_ctrl.f \
	&& ./obj_dir/Vio_ctrl_tb +verilator+error+limit+100 | tee /dev/stderr \
	| grep -F -- "*** TEST PASSED ***" > /dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
